// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bpu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/bpu_tb.sv
/*
 * Directed testbench for the branch prediction unit. Drives lookups and
 * writebacks on the top-level ports and checks npc and upd on both slots
 * against a model of the history, counter table and BTB.
 */
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;

   localparam int num_slot   = 2;
   localparam int upd_w      = 49;
   // About 720 cycles of tests, limit leaves a wide margin
   localparam int max_cycles = 4000;

   localparam logic [2:0] k_none = 3'b000;
   localparam logic [2:0] k_bcc  = 3'b100;
   localparam logic [2:0] k_breg = 3'b010;
   localparam logic [2:0] k_brel = 3'b001;

   logic                      clk;
   logic                      reset;
   logic                      re;
   logic [num_slot-1:0]       valid;
   logic [32*num_slot-1:0]    pc;
   logic [32*num_slot-1:0]    npc;
   logic [upd_w*num_slot-1:0] upd;
   logic                      bpu_wb;
   logic                      wb_is_bcc;
   logic                      wb_is_breg;
   logic                      wb_is_brel;
   logic                      wb_taken;
   logic [31:0]               wb_pc;
   logic [31:0]               wb_npc_act;
   logic [upd_w-1:0]          wb_upd;

   // Reference model of history and tables
   logic [7:0]       hist;
   logic [1:0]       pht_m   [256];
   logic             btb_v   [64];
   logic             btb_c   [64];
   logic [25:0]      btb_tag [64];
   logic [31:0]      btb_tgt [64];
   logic [31:0]      exp_npc [num_slot];
   logic [upd_w-1:0] exp_upd [num_slot];

   logic [31:0] rng;
   int          cycles = 0;
   int          checks;
   int          errors;
   int          test_start_errors;
   int          tests_run;
   int          tests_failed;
   string       test_name;

   bpu #(
      .P_FETCH_WIDTH (1)
   ) i_dut (
      .clk            (clk),
      .reset          (reset),
      .re             (re),
      .valid          (valid),
      .pc             (pc),
      .npc            (npc),
      .upd            (upd),
      .bpu_wb         (bpu_wb),
      .bpu_wb_is_bcc  (wb_is_bcc),
      .bpu_wb_is_breg (wb_is_breg),
      .bpu_wb_is_brel (wb_is_brel),
      .bpu_wb_taken   (wb_taken),
      .bpu_wb_pc      (wb_pc),
      .bpu_wb_npc_act (wb_npc_act),
      .bpu_wb_upd     (wb_upd)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout: run did not finish within %0d cycles", max_cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Small PC set with BTB index aliases (1000, 1040, 11000)
   function automatic logic [31:0] pick_pc(input logic [2:0] sel);
      case (sel)
         3'd0:    return 32'h0000_1000;
         3'd1:    return 32'h0000_1004;
         3'd2:    return 32'h0000_1040;
         3'd3:    return 32'h0000_2008;
         3'd4:    return 32'h8000_0010;
         3'd5:    return 32'h0000_10fc;
         3'd6:    return 32'h0001_1000;
         default: return 32'h0000_3333;
      endcase
   endfunction

   task automatic clear_model();
      hist = 8'h00;
      for (int i = 0; i < 256; i++)
         pht_m[i] = 2'd0;
      for (int i = 0; i < 64; i++)
      begin
         btb_v[i]   = 1'b0;
         btb_c[i]   = 1'b0;
         btb_tag[i] = 26'h0;
         btb_tgt[i] = 32'h0;
      end
      for (int s = 0; s < num_slot; s++)
      begin
         exp_npc[s] = 32'h0;
         exp_upd[s] = '0;
      end
   endtask

   // Record layout: count, PHT index, BTB index, target, taken
   function automatic logic [upd_w-1:0] predict_upd(input logic [31:0] p, input logic v);
      logic [7:0] pi;
      logic [5:0] bi;
      logic [1:0] cnt;
      logic       hit;
      logic       tk;
      pi  = p[7:0] ^ hist;
      bi  = p[5:0];
      cnt = pht_m[pi];
      hit = btb_v[bi] && (btb_tag[bi] == p[31:6]);
      tk  = v && hit && (!btb_c[bi] || cnt[1]);
      return {cnt, pi, bi, btb_tgt[bi], tk};
   endfunction

   task automatic apply_writeback(input logic [2:0] kind, input logic tk,
                                  input logic [31:0] wpc, input logic [31:0] wnpc,
                                  input logic [upd_w-1:0] wu);
      logic [1:0] cnt;
      logic [7:0] pi;
      cnt = wu[48:47];
      pi  = wu[46:39];
      if (kind[2])
      begin
         if (tk)
            pht_m[pi] = (cnt == 2'd3) ? 2'd3 : cnt + 2'd1;
         else
            pht_m[pi] = (cnt == 2'd0) ? 2'd0 : cnt - 2'd1;
         hist = {hist[6:0], tk};
      end
      if (tk && (kind != k_none))
      begin
         btb_v[wpc[5:0]]   = 1'b1;
         btb_c[wpc[5:0]]   = kind[2];
         btb_tag[wpc[5:0]] = wpc[31:6];
         btb_tgt[wpc[5:0]] = wnpc;
      end
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic check_outputs();
      for (int s = 0; s < num_slot; s++)
      begin
         check_value($sformatf("slot %0d npc", s), 64'(npc[s*32 +: 32]), 64'(exp_npc[s]));
         check_value($sformatf("slot %0d upd", s), 64'(upd[s*upd_w +: upd_w]),
                     64'(exp_upd[s]));
      end
   endtask

   function automatic logic got_taken(input int s);
      return upd[s*upd_w];
   endfunction

   function automatic logic [1:0] got_count(input int s);
      return upd[s*upd_w+47 +: 2];
   endfunction

   function automatic logic [7:0] got_idx(input int s);
      return upd[s*upd_w+39 +: 8];
   endfunction

   function automatic logic [31:0] got_npc(input int s);
      return npc[s*32 +: 32];
   endfunction

   // One lookup and/or writeback, sampled by the DUT at the second edge
   task automatic drive_cycle(input logic lk, input logic [31:0] p0, input logic [31:0] p1,
                              input logic [1:0] v, input logic wb_en, input logic [2:0] kind,
                              input logic tk, input logic [31:0] wpc,
                              input logic [31:0] wnpc, input logic [upd_w-1:0] wu);
      @(posedge clk);
      re         <= lk;
      valid      <= v;
      pc         <= {p1, p0};
      bpu_wb     <= wb_en;
      wb_is_bcc  <= kind[2];
      wb_is_breg <= kind[1];
      wb_is_brel <= kind[0];
      wb_taken   <= tk;
      wb_pc      <= wpc;
      wb_npc_act <= wnpc;
      wb_upd     <= wu;
      @(posedge clk);
      re     <= 1'b0;
      bpu_wb <= 1'b0;
      // Lookup reads the tables from before a write at the same edge
      if (lk)
      begin
         exp_upd[0] = predict_upd(p0, v[0]);
         exp_upd[1] = predict_upd(p1, v[1]);
         exp_npc[0] = btb_tgt[p0[5:0]];
         exp_npc[1] = btb_tgt[p1[5:0]];
      end
      if (wb_en)
         apply_writeback(kind, tk, wpc, wnpc, wu);
      @(negedge clk);
      check_outputs();
   endtask

   task automatic lookup(input logic [31:0] p0, input logic [31:0] p1, input logic [1:0] v);
      drive_cycle(1'b1, p0, p1, v, 1'b0, k_none, 1'b0, 32'h0, 32'h0, '0);
   endtask

   task automatic writeback(input logic [2:0] kind, input logic tk, input logic [31:0] wpc,
                            input logic [31:0] wnpc, input logic [upd_w-1:0] wu);
      drive_cycle(1'b0, 32'h0, 32'h0, 2'b00, 1'b1, kind, tk, wpc, wnpc, wu);
   endtask

   task automatic begin_test(input string name);
      test_name         = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors != test_start_errors)
      begin
         tests_failed++;
         $display("%s: FAILED with %0d errors", test_name, errors - test_start_errors);
      end
      else
         $display("%s: passed", test_name);
   endtask

   task automatic reset_lookup();
      begin_test("reset_lookup");
      lookup(32'h0000_1000, 32'h8000_2344, 2'b11);
      for (int s = 0; s < num_slot; s++)
      begin
         check_value($sformatf("slot %0d taken after reset", s), 64'(got_taken(s)), 64'd0);
         check_value($sformatf("slot %0d npc after reset", s), 64'(got_npc(s)), 64'd0);
      end
      end_test();
   endtask

   task automatic unconditional_install();
      begin_test("unconditional_install");
      writeback(k_brel, 1'b1, 32'h0000_1048, 32'h0000_2000, '0);
      lookup(32'h0000_1048, 32'h0000_0100, 2'b11);
      check_value("brel taken", 64'(got_taken(0)), 64'd1);
      check_value("brel target", 64'(got_npc(0)), 64'h2000);
      check_value("miss slot taken", 64'(got_taken(1)), 64'd0);
      writeback(k_breg, 1'b1, 32'h0000_3094, 32'h4444_0000, '0);
      lookup(32'h0000_1000, 32'h0000_3094, 2'b11);
      check_value("breg taken", 64'(got_taken(1)), 64'd1);
      check_value("breg target", 64'(got_npc(1)), 64'h4444_0000);
      // Same index as 1048, other tag
      lookup(32'h0000_1088, 32'h0000_1048, 2'b11);
      check_value("alias taken", 64'(got_taken(0)), 64'd0);
      check_value("hit beside alias", 64'(got_taken(1)), 64'd1);
      lookup(32'h0000_1048, 32'h0000_3094, 2'b10);
      check_value("invalid slot taken", 64'(got_taken(0)), 64'd0);
      check_value("invalid slot npc", 64'(got_npc(0)), 64'h2000);
      end_test();
   endtask

   task automatic counter_walk();
      logic [1:0]  cnt;
      logic [31:0] p;
      begin_test("counter_walk");
      // History fills with ones over 8 writebacks, then the index stays at ff
      for (int k = 0; k < 14; k++)
      begin
         cnt = (k < 8) ? 2'd0 : ((k >= 11) ? 2'd3 : 2'(k - 8));
         lookup(32'h0000_5100, 32'h0000_5104, 2'b01);
         check_value($sformatf("up walk %0d count", k), 64'(got_count(0)), 64'(cnt));
         check_value($sformatf("up walk %0d taken", k), 64'(got_taken(0)), 64'(cnt[1]));
         writeback(k_bcc, 1'b1, 32'h0000_5100, 32'h0000_6000, exp_upd[0]);
      end
      // PC chosen so the hashed index stays at ff while history drains
      for (int k = 0; k < 5; k++)
      begin
         cnt = (k < 3) ? 2'(3 - k) : 2'd0;
         p   = {24'h000070, 8'hff ^ hist};
         lookup(p, 32'h0000_5104, 2'b01);
         check_value($sformatf("down walk %0d index", k), 64'(got_idx(0)), 64'hff);
         check_value($sformatf("down walk %0d count", k), 64'(got_count(0)), 64'(cnt));
         writeback(k_bcc, 1'b0, p, 32'h0, exp_upd[0]);
      end
      end_test();
   endtask

   task automatic history_shift();
      logic [7:0] h;
      begin_test("history_shift");
      h = hist;
      lookup(32'h0000_7a30, 32'h0000_7a34, 2'b11);
      check_value("index before bcc", 64'(got_idx(0)), 64'(8'h30 ^ h));
      writeback(k_bcc, 1'b1, 32'h0000_7a30, 32'h0000_7000, exp_upd[0]);
      // Taken outcome enters at the LSB
      h = {h[6:0], 1'b1};
      lookup(32'h0000_7a30, 32'h0000_7a34, 2'b11);
      check_value("index after bcc", 64'(got_idx(0)), 64'(8'h30 ^ h));
      check_value("slot 1 index after bcc", 64'(got_idx(1)), 64'(8'h34 ^ h));
      writeback(k_brel, 1'b1, 32'h0000_7a34, 32'h0000_9000, '0);
      lookup(32'h0000_7a30, 32'h0000_7a34, 2'b11);
      check_value("index after brel", 64'(got_idx(0)), 64'(8'h30 ^ h));
      end_test();
   endtask

   task automatic slot_independence();
      begin_test("slot_independence");
      writeback(k_brel, 1'b1, 32'h0000_8010, 32'h0000_a000, '0);
      lookup(32'h0000_8010, 32'h0000_8024, 2'b11);
      check_value("slot 0 hit", 64'(got_taken(0)), 64'd1);
      check_value("slot 1 miss", 64'(got_taken(1)), 64'd0);
      lookup(32'h0000_8024, 32'h0000_8010, 2'b11);
      check_value("slot 0 miss", 64'(got_taken(0)), 64'd0);
      check_value("slot 1 hit", 64'(got_taken(1)), 64'd1);
      // re low, new PCs and an install of 8024 must not move the outputs
      drive_cycle(1'b0, 32'h0000_8024, 32'h0000_8024, 2'b11, 1'b1, k_breg, 1'b1,
                  32'h0000_8024, 32'h0000_b000, '0);
      check_value("held slot 1 taken", 64'(got_taken(1)), 64'd1);
      check_value("held slot 1 npc", 64'(got_npc(1)), 64'ha000);
      lookup(32'h0000_8024, 32'h0000_8010, 2'b11);
      check_value("new install taken", 64'(got_taken(0)), 64'd1);
      check_value("new install npc", 64'(got_npc(0)), 64'hb000);
      end_test();
   endtask

   task automatic random_mix();
      logic [31:0] r;
      logic [31:0] r2;
      logic [2:0]  kind;
      begin_test("random_mix");
      for (int n = 0; n < 300; n++)
      begin
         rng = xorshift(rng);
         r   = rng;
         rng = xorshift(rng);
         r2  = rng;
         case (r[12:11])
            2'd0:    kind = k_bcc;
            2'd1:    kind = k_breg;
            2'd2:    kind = k_brel;
            default: kind = k_none;
         endcase
         drive_cycle(r[0] | r[1], pick_pc(r[4:2]), pick_pc(r[7:5]), r[9:8], r[10], kind,
                     r[13], pick_pc(r[16:14]), r2, exp_upd[r[17]]);
      end
      end_test();
   endtask

   initial
   begin
      rng          = 32'hd1427639;
      checks       = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      clear_model();
      reset      <= 1'b1;
      re         <= 1'b0;
      valid      <= '0;
      pc         <= '0;
      bpu_wb     <= 1'b0;
      wb_is_bcc  <= 1'b0;
      wb_is_breg <= 1'b0;
      wb_is_brel <= 1'b0;
      wb_taken   <= 1'b0;
      wb_pc      <= 32'h0;
      wb_npc_act <= 32'h0;
      wb_upd     <= '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      reset_lookup();
      unconditional_install();
      counter_walk();
      history_shift();
      slot_independence();
      random_mix();

      $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
rtl/bpu_pkg.sv
rtl/bpu_wb_if.sv
rtl/bpu_rf.sv
rtl/gshare_pht.sv
rtl/btb.sv
rtl/pred_combine.sv
rtl/bpu.sv
bench/bpu_tb.sv

// File: rtl/bpu.sv
/*
 * Branch prediction unit top level. Flat slot vectors on the ports,
 * gshare direction and BTB target lookups merged by the combiner.
 */
`timescale 1ns/1ps
`default_nettype none

module bpu
#(
   parameter  int P_FETCH_WIDTH = 1,
   localparam int NUM_SLOT      = 1 << P_FETCH_WIDTH,
   localparam int UPD_W         = $bits(bpu_pkg::bpu_upd_t)
)
(
   input  wire logic                              clk,
   input  wire logic                              reset,
   input  wire logic                              re,
   input  wire logic [NUM_SLOT-1:0]               valid,
   input  wire logic [bpu_pkg::pc_w*NUM_SLOT-1:0] pc,
   output logic [bpu_pkg::pc_w*NUM_SLOT-1:0]      npc,
   output logic [UPD_W*NUM_SLOT-1:0]              upd,
   // Writeback of a resolved branch
   input  wire logic                              bpu_wb,
   input  wire logic                              bpu_wb_is_bcc,
   input  wire logic                              bpu_wb_is_breg,
   input  wire logic                              bpu_wb_is_brel,
   input  wire logic                              bpu_wb_taken,
   input  wire logic [bpu_pkg::pc_w-1:0]          bpu_wb_pc,
   input  wire logic [bpu_pkg::pc_w-1:0]          bpu_wb_npc_act,
   input  wire logic [UPD_W-1:0]                  bpu_wb_upd
);

   import bpu_pkg::*;

   logic [pc_w-1:0] slot_pc   [NUM_SLOT];
   logic            pht_taken [NUM_SLOT];
   pht_cnt_t        pht_count [NUM_SLOT];
   pht_idx_t        pht_idx   [NUM_SLOT];
   logic            hit       [NUM_SLOT];
   logic            is_bcc    [NUM_SLOT];
   logic [pc_w-1:0] target    [NUM_SLOT];
   btb_idx_t        btb_idx   [NUM_SLOT];
   logic [pc_w-1:0] slot_npc  [NUM_SLOT];
   bpu_upd_t        slot_upd  [NUM_SLOT];

   bpu_wb_if wb_if ();

   assign wb_if.wb      = bpu_wb;
   assign wb_if.is_bcc  = bpu_wb_is_bcc;
   assign wb_if.is_breg = bpu_wb_is_breg;
   assign wb_if.is_brel = bpu_wb_is_brel;
   assign wb_if.taken   = bpu_wb_taken;
   assign wb_if.pc      = bpu_wb_pc;
   assign wb_if.npc_act = bpu_wb_npc_act;
   assign wb_if.upd     = bpu_wb_upd;

   // Slot 0 sits in the low bits of each flat vector
   for (genvar i = 0; i < NUM_SLOT; i++)
   begin : g_slot
      assign slot_pc[i]               = pc[i*pc_w +: pc_w];
      assign npc[i*pc_w +: pc_w]      = slot_npc[i];
      assign upd[i*UPD_W +: UPD_W]    = slot_upd[i];
   end

   gshare_pht #(
      .P_FETCH_WIDTH (P_FETCH_WIDTH)
   ) i_pht (
      .clk       (clk),
      .reset     (reset),
      .re        (re),
      .pc        (slot_pc),
      .wb        (wb_if.pht),
      .pht_taken (pht_taken),
      .pht_count (pht_count),
      .pht_idx   (pht_idx)
   );

   btb #(
      .P_FETCH_WIDTH (P_FETCH_WIDTH)
   ) i_btb (
      .clk       (clk),
      .reset     (reset),
      .re        (re),
      .pc        (slot_pc),
      .wb        (wb_if.btb),
      .hit       (hit),
      .is_bcc    (is_bcc),
      .target    (target),
      .btb_idx   (btb_idx)
   );

   pred_combine #(
      .P_FETCH_WIDTH (P_FETCH_WIDTH)
   ) i_combine (
      .clk       (clk),
      .reset     (reset),
      .re        (re),
      .valid     (valid),
      .pht_taken (pht_taken),
      .pht_count (pht_count),
      .pht_idx   (pht_idx),
      .hit       (hit),
      .is_bcc    (is_bcc),
      .target    (target),
      .btb_idx   (btb_idx),
      .npc       (slot_npc),
      .upd       (slot_upd)
   );

endmodule

`default_nettype wire

// File: rtl/bpu_pkg.sv
/*
 * Shared widths, table sizes and record types of the branch prediction unit.
 * Imported by the tables, the combiner, the writeback interface and the top.
 */
`default_nettype none

package bpu_pkg;

   // PC and table geometry
   localparam int pc_w      = 32;
   localparam int pht_p_num = 8;
   localparam int btb_p_num = 6;

   // BTB tag covers every PC bit above the index
   localparam int tag_w     = pc_w - btb_p_num;

   // 2-bit saturating counter, MSB is the taken direction
   typedef logic [1:0]           pht_cnt_t;

   typedef logic [pht_p_num-1:0] pht_idx_t;
   typedef logic [btb_p_num-1:0] btb_idx_t;

   // One BTB entry
   typedef struct packed {
      logic             valid;
      logic             is_bcc;
      logic [tag_w-1:0] tag;
      logic [pc_w-1:0]  target;
   } btb_entry_t;

   // Record sent with each slot down the pipe and returned at writeback
   typedef struct packed {
      pht_cnt_t         pht_count;
      pht_idx_t         pht_idx;
      btb_idx_t         btb_idx;
      logic [pc_w-1:0]  pred_tgt;
      logic             pred_taken;
   } bpu_upd_t;

endpackage

`default_nettype wire

// File: rtl/bpu_rf.sv
/*
 * Register file with several registered read ports and one write port.
 * Reads return the contents from before a write at the same edge.
 */
`timescale 1ns/1ps
`default_nettype none

module bpu_rf
#(
   parameter type entry_t = logic [1:0],
   parameter int  AW       = 8,
   parameter int  NUM_READ = 2
)
(
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire logic [NUM_READ-1:0] re,
   input  wire logic [AW-1:0]       raddr [NUM_READ],
   output entry_t                   rdata [NUM_READ],
   input  wire logic                we,
   input  wire logic [AW-1:0]       waddr,
   input  entry_t                   wdata
);

   entry_t mem [1<<AW];

   // Write port, whole table cleared on reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < (1 << AW); i++)
            mem[i] <= '0;
      end
      else if (we)
         mem[waddr] <= wdata;
   end

   // Read ports hold while their enable is low
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int r = 0; r < NUM_READ; r++)
            rdata[r] <= '0;
      end
      else
      begin
         for (int r = 0; r < NUM_READ; r++)
            if (re[r])
               rdata[r] <= mem[raddr[r]];
      end
   end

endmodule

`default_nettype wire

// File: rtl/bpu_wb_if.sv
/*
 * Resolved-branch writeback bundle. The top level drives it through src,
 * the PHT and the BTB each take the subset they need.
 */
`timescale 1ns/1ps
`default_nettype none

interface bpu_wb_if;

   import bpu_pkg::*;

   logic            wb;
   logic            is_bcc;
   logic            is_breg;
   logic            is_brel;
   logic            taken;
   logic [pc_w-1:0] pc;
   logic [pc_w-1:0] npc_act;
   bpu_upd_t        upd;

   modport src (
      output wb, is_bcc, is_breg, is_brel, taken, pc, npc_act, upd
   );

   // Direction table only needs the record it handed out
   modport pht (
      input wb, is_bcc, taken, upd
   );

   modport btb (
      input wb, is_bcc, is_breg, is_brel, taken, pc, npc_act
   );

endinterface

`default_nettype wire

// File: rtl/btb.sv
/*
 * Direct-mapped branch target buffer. One tagged lookup per fetch slot,
 * taken branches of any kind are installed at writeback.
 */
`timescale 1ns/1ps
`default_nettype none

module btb
#(
   parameter  int P_FETCH_WIDTH = 1,
   localparam int NUM_SLOT      = 1 << P_FETCH_WIDTH
)
(
   input  wire logic                     clk,
   input  wire logic                     reset,
   input  wire logic                     re,
   input  wire logic [bpu_pkg::pc_w-1:0] pc [NUM_SLOT],
   bpu_wb_if.btb                         wb,
   output logic                          hit     [NUM_SLOT],
   output logic                          is_bcc  [NUM_SLOT],
   output logic [bpu_pkg::pc_w-1:0]      target  [NUM_SLOT],
   output bpu_pkg::btb_idx_t             btb_idx [NUM_SLOT]
);

   import bpu_pkg::*;

   logic [pc_w-1:0] pc_q   [NUM_SLOT];
   btb_idx_t        rd_idx [NUM_SLOT];
   btb_entry_t      ent    [NUM_SLOT];
   btb_entry_t      wr_ent;
   logic            wr_en;

   always_comb
   begin
      for (int i = 0; i < NUM_SLOT; i++)
         rd_idx[i] = pc[i][btb_p_num-1:0];
   end

   // PC kept for the tag compare one cycle later
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < NUM_SLOT; i++)
            pc_q[i] <= '0;
      end
      else if (re)
      begin
         for (int i = 0; i < NUM_SLOT; i++)
            pc_q[i] <= pc[i];
      end
   end

   always_comb
   begin
      for (int i = 0; i < NUM_SLOT; i++)
      begin
         hit[i]     = ent[i].valid & (ent[i].tag == pc_q[i][pc_w-1:btb_p_num]);
         is_bcc[i]  = ent[i].is_bcc;
         target[i]  = ent[i].target;
         btb_idx[i] = pc_q[i][btb_p_num-1:0];
      end
   end

   // Install only branches that actually went somewhere else
   assign wr_en = wb.wb & wb.taken & (wb.is_bcc | wb.is_breg | wb.is_brel);

   always_comb
   begin
      wr_ent.valid  = 1'b1;
      wr_ent.is_bcc = wb.is_bcc;
      wr_ent.tag    = wb.pc[pc_w-1:btb_p_num];
      wr_ent.target = wb.npc_act;
   end

   bpu_rf #(
      .entry_t  (btb_entry_t),
      .AW       (btb_p_num),
      .NUM_READ (NUM_SLOT)
   ) i_btb_rf (
      .clk      (clk),
      .reset    (reset),
      .re       ({NUM_SLOT{re}}),
      .raddr    (rd_idx),
      .rdata    (ent),
      .we       (wr_en),
      .waddr    (wb.pc[btb_p_num-1:0]),
      .wdata    (wr_ent)
   );

endmodule

`default_nettype wire

// File: rtl/gshare_pht.sv
/*
 * Gshare direction predictor. Owns the global history, looks up one counter
 * per fetch slot and trains the counter of a resolved conditional branch.
 */
`timescale 1ns/1ps
`default_nettype none

module gshare_pht
#(
   parameter  int P_FETCH_WIDTH = 1,
   localparam int NUM_SLOT      = 1 << P_FETCH_WIDTH
)
(
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  re,
   input  wire logic [bpu_pkg::pc_w-1:0] pc [NUM_SLOT],
   bpu_wb_if.pht                      wb,
   output logic                       pht_taken [NUM_SLOT],
   output bpu_pkg::pht_cnt_t          pht_count [NUM_SLOT],
   output bpu_pkg::pht_idx_t          pht_idx   [NUM_SLOT]
);

   import bpu_pkg::*;

   pht_idx_t ghsr;
   pht_idx_t lookup_idx [NUM_SLOT];
   pht_cnt_t cnt_nxt;
   logic     upd_we;

   // Hash of low PC bits with the history
   always_comb
   begin
      for (int i = 0; i < NUM_SLOT; i++)
         lookup_idx[i] = pc[i][pht_p_num-1:0] ^ ghsr;
   end

   // Index travels with the counter read so it can be written back later
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < NUM_SLOT; i++)
            pht_idx[i] <= '0;
      end
      else if (re)
      begin
         for (int i = 0; i < NUM_SLOT; i++)
            pht_idx[i] <= lookup_idx[i];
      end
   end

   always_comb
   begin
      for (int i = 0; i < NUM_SLOT; i++)
         pht_taken[i] = pht_count[i][1];
   end

   assign upd_we = wb.wb & wb.is_bcc;

   // Saturating step from the counter value seen at lookup
   always_comb
   begin
      if (wb.taken)
         cnt_nxt = (wb.upd.pht_count == 2'b11) ? 2'b11 : wb.upd.pht_count + 2'b01;
      else
         cnt_nxt = (wb.upd.pht_count == 2'b00) ? 2'b00 : wb.upd.pht_count - 2'b01;
   end

   // Global history, newest outcome at the LSB
   always_ff @(posedge clk)
   begin
      if (reset)
         ghsr <= '0;
      else if (upd_we)
         ghsr <= {ghsr[pht_p_num-2:0], wb.taken};
   end

   bpu_rf #(
      .entry_t  (pht_cnt_t),
      .AW       (pht_p_num),
      .NUM_READ (NUM_SLOT)
   ) i_pht_rf (
      .clk      (clk),
      .reset    (reset),
      .re       ({NUM_SLOT{re}}),
      .raddr    (lookup_idx),
      .rdata    (pht_count),
      .we       (upd_we),
      .waddr    (wb.upd.pht_idx),
      .wdata    (cnt_nxt)
   );

endmodule

`default_nettype wire

// File: rtl/pred_combine.sv
/*
 * Per-slot merge of direction and target lookups into next PC and the
 * update record returned at writeback.
 */
`timescale 1ns/1ps
`default_nettype none

module pred_combine
#(
   parameter  int P_FETCH_WIDTH = 1,
   localparam int NUM_SLOT      = 1 << P_FETCH_WIDTH
)
(
   input  wire logic                     clk,
   input  wire logic                     reset,
   input  wire logic                     re,
   input  wire logic [NUM_SLOT-1:0]      valid,
   input  wire logic                     pht_taken [NUM_SLOT],
   input  bpu_pkg::pht_cnt_t             pht_count [NUM_SLOT],
   input  bpu_pkg::pht_idx_t             pht_idx   [NUM_SLOT],
   input  wire logic                     hit       [NUM_SLOT],
   input  wire logic                     is_bcc    [NUM_SLOT],
   input  wire logic [bpu_pkg::pc_w-1:0] target    [NUM_SLOT],
   input  bpu_pkg::btb_idx_t             btb_idx   [NUM_SLOT],
   output logic [bpu_pkg::pc_w-1:0]      npc       [NUM_SLOT],
   output bpu_pkg::bpu_upd_t             upd       [NUM_SLOT]
);

   import bpu_pkg::*;

   logic [NUM_SLOT-1:0] valid_q;
   logic [NUM_SLOT-1:0] taken;

   // Lines valid up with the table read data
   always_ff @(posedge clk)
   begin
      if (reset)
         valid_q <= '0;
      else if (re)
         valid_q <= valid;
   end

   always_comb
   begin
      for (int i = 0; i < NUM_SLOT; i++)
      begin
         // Unconditional hits always taken, conditional ones follow the counter
         taken[i] = valid_q[i] & hit[i] & (~is_bcc[i] | pht_taken[i]);
         npc[i]   = target[i];

         upd[i].pht_count  = pht_count[i];
         upd[i].pht_idx    = pht_idx[i];
         upd[i].btb_idx    = btb_idx[i];
         upd[i].pred_tgt   = target[i];
         upd[i].pred_taken = taken[i];
      end
   end

endmodule

`default_nettype wire
